// ==== project.f ====
displayPkg.sv
axiLiteRegs.sv
panelSequencer.sv
doneCollector.sv
displayTop.sv
tbPanelModel.sv
tbDisplayTop.sv

// ==== tbDisplayTop.sv ====
module tbDisplayTop;
  timeunit 1ns;
  timeprecision 1ps;
  import displayPkg::*;

  typedef logic [8:0] byteQ_t [$];

  localparam int CLK_PERIOD = 100;
  localparam int AXI_OVH    = 60;  // register writes and status polls per test
  localparam int LEN_INIT   = 2 * 7 + WAIT_RESET + WAIT_SLEEPOUT + 4 + AXI_OVH;
  localparam int LEN_WIN    = 2 * 5 + 4 + AXI_OVH;
  localparam int LEN_FILL   = 2 + 4 * 40 + 4 + AXI_OVH;
  localparam int LEN_OFF    = 2 * 2 + WAIT_DISPOFF + WAIT_SLEEPIN + 4 + AXI_OVH;
  localparam int LEN_ON     = 2 * 2 + WAIT_SLEEPOUT + WAIT_DISPON + 4 + AXI_OVH;
  localparam int TEST_SUM   = 100 + LEN_INIT + 2 * LEN_WIN + 2 * LEN_FILL + LEN_OFF + LEN_ON + 100;
  localparam int TIMEOUT_CYCLES = 2 * TEST_SUM + 2000;

  logic clk = 1'b0;
  logic rst;
  logic [ADDR_W-1:0] awaddr, araddr;
  logic awvalid, wvalid, bready, arvalid, rready;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W/8-1:0] wstrb;
  logic awready, wready, bvalid, arready, rvalid, irq;
  logic [1:0] bresp, rresp;
  logic [DATA_W-1:0] rdata;
  logic [NUM_PANELS-1:0] csx, dcx, wrx;
  logic [7:0] data [NUM_PANELS];

  byteQ_t expQ [NUM_PANELS];
  int valueErrs = 0;
  int otherErrs = 0;
  logic [31:0] rngState = 32'd4225;

  displayTop UUT (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .irq(irq), .csx(csx), .dcx(dcx), .wrx(wrx), .data(data)
  );

  tbPanelModel #(.idx(0)) pm0 (.rst(rst), .csx(csx[0]), .dcx(dcx[0]), .wrx(wrx[0]), .data(data[0]));
  tbPanelModel #(.idx(1)) pm1 (.rst(rst), .csx(csx[1]), .dcx(dcx[1]), .wrx(wrx[1]), .data(data[1]));

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // expected panel bytes, {dcx, data}
  function automatic byteQ_t expectBytes(input panelOp_t op, input logic [31:0] p, input int n);
    byteQ_t q;
    case (op)
      OP_INIT: begin
        q.push_back({1'b0, 8'h01});
        q.push_back({1'b0, 8'h11});
        q.push_back({1'b0, 8'h3A});
        q.push_back({1'b1, 8'h55});
        q.push_back({1'b0, 8'h36});
        q.push_back({1'b1, 8'h30});
        q.push_back({1'b0, 8'h29});
      end
      OP_COLSET, OP_PAGESET: begin
        q.push_back({1'b0, (op == OP_COLSET) ? 8'h2A : 8'h2B});
        for (int i = 3; i >= 0; i--) begin
          q.push_back({1'b1, p[8*i +: 8]});
        end
      end
      OP_FILL: begin
        q.push_back({1'b0, 8'h2C});
        for (int i = 0; i < n; i++) begin
          q.push_back({1'b1, p[15:8]});
          q.push_back({1'b1, p[7:0]});
        end
      end
      OP_DISPON: begin
        q.push_back({1'b0, 8'h11});
        q.push_back({1'b0, 8'h29});
      end
      OP_DISPOFF: begin
        q.push_back({1'b0, 8'h28});
        q.push_back({1'b0, 8'h10});
      end
      default: ;
    endcase
    return q;
  endfunction

  task automatic checkEq(input string name, input logic [31:0] expv, input logic [31:0] gotv);
    assert (gotv === expv)
      else begin
        $display("ERR %0t %s expected %h got %h", $time, name, expv, gotv);
        valueErrs++;
      end
  endtask

  task automatic compareByte(input int p, input logic [8:0] gotB);
    logic [8:0] expB;
    if (expQ[p].size() == 0) begin
      $display("panel %0d sent byte %h at %0t with nothing expected", p, gotB, $time);
      otherErrs++;
    end else begin
      expB = expQ[p].pop_front();
      assert (gotB === expB)
        else begin
          $display("ERR %0t panel%0d {dcx,data} expected %h got %h", $time, p, expB, gotB);
          valueErrs++;
        end
    end
  endtask

  // comparator, drains the captured bytes
  always @(negedge clk) begin
    while (pm0.got.size() > 0) compareByte(0, pm0.got.pop_front());
    while (pm1.got.size() > 0) compareByte(1, pm1.got.pop_front());
  end

  task automatic axiWrite(input logic [7:0] addr, input logic [31:0] value,
                          output logic [1:0] resp);
    @(posedge clk);
    #5;
    awaddr  = addr;
    wdata   = value;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    #5;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    resp = bresp;  // bready left to the caller
  endtask

  task automatic axiRead(input logic [7:0] addr, output logic [31:0] value,
                         output logic [1:0] resp);
    @(posedge clk);
    #5;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #5;
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    value = rdata;
    resp  = rresp;
  endtask

  task automatic runOp(input int p, input panelOp_t op, input logic [31:0] prm, input int n);
    byteQ_t q;
    logic [1:0] resp;
    logic [7:0] base;
    base = PANEL_BASE + 8'(p) * PANEL_STRIDE;
    axiWrite(base + OFS_PARAM, prm, resp);
    checkEq("bresp", RESP_OKAY, resp);
    axiWrite(base + OFS_COUNT, n, resp);
    checkEq("bresp", RESP_OKAY, resp);
    q = expectBytes(op, prm, n);
    foreach (q[i]) expQ[p].push_back(q[i]);
    axiWrite(base + OFS_CMD, 32'(op), resp);
    checkEq("bresp", RESP_OKAY, resp);
  endtask

  // poll STATUS until the busy bit drops, then make sure every byte came out
  task automatic waitIdle(input int p);
    logic [31:0] v;
    logic [1:0] r;
    do begin
      axiRead(REG_STATUS, v, r);
    end while (v[p] !== 1'b0);
    repeat (3) @(negedge clk);
    assert (expQ[p].size() == 0)
      else begin
        $display("panel %0d finished with %0d expected bytes never sent", p, expQ[p].size());
        otherErrs++;
        expQ[p].delete();
      end
  endtask

  task automatic printCounts();
    $display("errors: value %0d, other %0d, bus %0d", valueErrs, otherErrs,
             pm0.busErrs + pm1.busErrs);
  endtask

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("run timed out after %0d cycles, a test never finished", TIMEOUT_CYCLES);
    printCounts();
    $display("** FAIL **");
    $finish;
  end

  initial begin
    logic [31:0] v;
    logic [1:0] r;
    logic [31:0] colour;
    int n;
    rst = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b1;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b1;
    repeat (10) @(posedge clk);
    #5;
    rst = 1'b0;

    // reset state and unmapped access
    @(negedge clk);
    checkEq("csx", 2'b11, csx);
    checkEq("wrx", 2'b11, wrx);
    checkEq("dcx", 2'b11, dcx);
    checkEq("data0", 8'h00, data[0]);
    checkEq("data1", 8'h00, data[1]);
    checkEq("irq", 1'b0, irq);
    checkEq("bvalid", 1'b0, bvalid);
    checkEq("rvalid", 1'b0, rvalid);
    axiRead(REG_STATUS, v, r);
    checkEq("STATUS", 32'h0, v);
    checkEq("rresp", RESP_OKAY, r);
    axiRead(8'h0C, v, r);
    checkEq("rresp", RESP_SLVERR, r);
    checkEq("rdata", 32'h0, v);
    axiRead(8'h40, v, r);
    checkEq("rresp", RESP_SLVERR, r);
    axiWrite(8'h0C, 32'h1, r);
    checkEq("bresp", RESP_SLVERR, r);

    // init
    runOp(0, OP_INIT, 32'h0, 0);
    waitIdle(0);
    assert (pm0.resetGap >= (WAIT_RESET + 2) * CLK_PERIOD)
      else begin
        $display("sleep out came only %0t after software reset", pm0.resetGap);
        otherErrs++;
      end
    assert (pm0.sleepGap >= (WAIT_SLEEPOUT + 2) * CLK_PERIOD)
      else begin
        $display("next command came only %0t after sleep out", pm0.sleepGap);
        otherErrs++;
      end

    // window commands
    runOp(0, OP_COLSET, nextRand(), 0);
    waitIdle(0);
    runOp(0, OP_PAGESET, nextRand(), 0);
    waitIdle(0);

    // fill
    colour = nextRand();
    n = 1 + int'(nextRand() % 40);
    runOp(0, OP_FILL, colour, n);
    waitIdle(0);

    // both panels in flight, busy panel rejects a command
    runOp(0, OP_DISPOFF, 32'h0, 0);
    colour = nextRand();
    n = 1 + int'(nextRand() % 40);
    runOp(1, OP_FILL, colour, n);
    axiRead(REG_STATUS, v, r);
    checkEq("STATUS.busy", 2'b11, v[1:0]);
    @(posedge clk);
    #5;
    bready = 1'b0;  // response held back, panels keep going
    axiWrite(PANEL_BASE + OFS_CMD, 32'(OP_DISPON), r);
    checkEq("bresp", RESP_SLVERR, r);
    repeat (20) @(negedge clk);
    checkEq("bvalid", 1'b1, bvalid);
    @(posedge clk);
    #5;
    bready = 1'b1;
    waitIdle(1);
    waitIdle(0);

    // status and interrupt
    axiWrite(REG_STATUS, 32'h300, r);
    axiWrite(REG_IRQEN, 32'h0, r);
    runOp(1, OP_DISPON, 32'h0, 0);
    axiRead(REG_STATUS, v, r);
    checkEq("STATUS.busy", 2'b10, v[1:0]);
    waitIdle(1);
    axiRead(REG_STATUS, v, r);
    checkEq("STATUS.done", 2'b10, v[9:8]);
    checkEq("irq", 1'b0, irq);
    axiWrite(REG_IRQEN, 32'h1, r);
    repeat (3) @(negedge clk);
    checkEq("irq", 1'b0, irq);
    axiWrite(REG_IRQEN, 32'h2, r);
    repeat (3) @(negedge clk);
    checkEq("irq", 1'b1, irq);
    axiWrite(REG_STATUS, 32'h200, r);
    repeat (3) @(negedge clk);
    checkEq("irq", 1'b0, irq);
    axiRead(REG_STATUS, v, r);
    checkEq("STATUS.done", 2'b00, v[9:8]);

    repeat (5) @(posedge clk);
    printCounts();
    if (valueErrs + otherErrs + pm0.busErrs + pm1.busErrs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== tbPanelModel.sv ====
module tbPanelModel #(
  parameter int idx = 0
) (
  input logic       rst,
  input logic       csx,
  input logic       dcx,
  input logic       wrx,
  input logic [7:0] data
);
  timeunit 1ns;
  timeprecision 1ps;
  import displayPkg::*;

  logic [8:0] got [$];  // {dcx, data} per write strobe
  int         busErrs = 0;

  // spacing after the two slow commands
  time        resetGap = 0;
  time        sleepGap = 0;
  logic [7:0] lastCmd = 8'h00;
  time        lastCmdAt = 0;

  always @(posedge wrx) begin
    if (rst !== 1'b1) begin
      assert (csx === 1'b0)
        else begin
          $display("panel %0d: wrx rose at %0t while csx was high", idx, $time);
          busErrs++;
        end
      assert (!$isunknown({dcx, data}))
        else begin
          $display("panel %0d: dcx or data unknown at a write strobe at %0t", idx, $time);
          busErrs++;
        end
      got.push_back({dcx, data});
      if (dcx === 1'b0) begin
        if (lastCmd == CMD_SWRESET) begin
          resetGap = $time - lastCmdAt;
        end
        if (lastCmd == CMD_SLPOUT) begin
          sleepGap = $time - lastCmdAt;
        end
        lastCmd   = data;
        lastCmdAt = $time;
      end
    end
  end

  // wrx only falls inside a csx frame
  always @(negedge wrx) begin
    if (rst !== 1'b1) begin
      assert (csx === 1'b0)
        else begin
          $display("panel %0d: wrx fell at %0t outside a csx frame", idx, $time);
          busErrs++;
        end
    end
  end

endmodule

// ==== displayTop.sv ====
module displayTop (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [displayPkg::ADDR_W-1:0]     awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [displayPkg::DATA_W-1:0]     wdata,
  input  logic [displayPkg::DATA_W/8-1:0]   wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  input  logic [displayPkg::ADDR_W-1:0]     araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [displayPkg::DATA_W-1:0]     rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  output logic                              irq,
  output logic [displayPkg::NUM_PANELS-1:0] csx,
  output logic [displayPkg::NUM_PANELS-1:0] dcx,
  output logic [displayPkg::NUM_PANELS-1:0] wrx,
  output logic [7:0]                        data [displayPkg::NUM_PANELS]
);
  import displayPkg::*;

  logic [NUM_PANELS-1:0] start;
  logic [NUM_PANELS-1:0] busy;
  logic [NUM_PANELS-1:0] done;
  panelOp_t              op [NUM_PANELS];
  logic [DATA_W-1:0]     param [NUM_PANELS];
  logic [COUNT_W-1:0]    count [NUM_PANELS];
  logic [NUM_PANELS-1:0] doneBits;
  logic [NUM_PANELS-1:0] clearMask;
  logic                  clearStrobe;
  logic [NUM_PANELS-1:0] irqEn;

  axiLiteRegs uRegs (
    .clk         (clk),
    .rst         (rst),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wvalid      (wvalid),
    .wready      (wready),
    .bresp       (bresp),
    .bvalid      (bvalid),
    .bready      (bready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rready      (rready),
    .start       (start),
    .op          (op),
    .param       (param),
    .count       (count),
    .busy        (busy),
    .doneBits    (doneBits),
    .clearMask   (clearMask),
    .clearStrobe (clearStrobe),
    .irqEn       (irqEn)
  );

  // one sequencer per panel, all identical
  for (genvar p = 0; p < NUM_PANELS; p++) begin : gPanel
    panelSequencer #(
      .panelIndex (p)
    ) uSeq (
      .clk   (clk),
      .rst   (rst),
      .start (start[p]),
      .op    (op[p]),
      .param (param[p]),
      .count (count[p]),
      .busy  (busy[p]),
      .done  (done[p]),
      .csx   (csx[p]),
      .dcx   (dcx[p]),
      .wrx   (wrx[p]),
      .data  (data[p])
    );
  end

  doneCollector uDone (
    .clk         (clk),
    .rst         (rst),
    .done        (done),
    .clearMask   (clearMask),
    .clearStrobe (clearStrobe),
    .irqEn       (irqEn),
    .doneBits    (doneBits),
    .irq         (irq)
  );

endmodule

// ==== doneCollector.sv ====
module doneCollector (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [displayPkg::NUM_PANELS-1:0] done,
  input  logic [displayPkg::NUM_PANELS-1:0] clearMask,
  input  logic                              clearStrobe,
  input  logic [displayPkg::NUM_PANELS-1:0] irqEn,
  output logic [displayPkg::NUM_PANELS-1:0] doneBits,
  output logic                              irq
);
  import displayPkg::*;

  logic [NUM_PANELS-1:0] clearBits;
  logic [NUM_PANELS-1:0] nextBits;

  assign clearBits = clearStrobe ? clearMask : '0;

  // set wins over clear
  assign nextBits = (doneBits & ~clearBits) | done;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      doneBits <= '0;
      irq      <= 1'b0;
    end else begin
      doneBits <= nextBits;
      irq      <= |(nextBits & irqEn);  // tracks doneBits cycle for cycle
    end
  end

endmodule

// ==== panelSequencer.sv ====
module panelSequencer #(
  parameter int panelIndex = 0
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  displayPkg::panelOp_t           op,
  input  logic [displayPkg::DATA_W-1:0]  param,
  input  logic [displayPkg::COUNT_W-1:0] count,
  output logic                           busy,
  output logic                           done,
  output logic                           csx,
  output logic                           dcx,
  output logic                           wrx,
  output logic [7:0]                     data
);
  import displayPkg::*;

  typedef enum logic [2:0] {K_CMD, K_DATA, K_WAIT, K_PIXEL, K_END} stepKind_t;
  typedef enum logic [1:0] {S_IDLE, S_RUN, S_WAIT, S_CLOSE} state_t;

  typedef struct packed {
    stepKind_t         kind;
    logic [7:0]        value;
    logic [WAIT_W-1:0] len;
  } step_t;

  state_t             state;
  panelOp_t           curOp;
  logic [3:0]         stepIdx;
  logic               phase;    // second half of a byte, wrx back high
  logic               lowByte;  // pixel half
  logic [WAIT_W-1:0]  waitCnt;
  logic [COUNT_W-1:0] pixLeft;
  logic [DATA_W-1:0]  curParam;
  step_t              step;

  function automatic step_t mkStep(input stepKind_t k, input logic [7:0] b, input int n);
    step_t s;
    s.kind  = k;
    s.value = b;
    s.len   = WAIT_W'(n);
    return s;
  endfunction

  // micro-program, one entry per step index
  always_comb begin
    step = mkStep(K_END, 8'h00, 0);
    case (curOp)
      OP_INIT: begin
        case (stepIdx)
          4'd0: step = mkStep(K_CMD, CMD_SWRESET, 0);
          4'd1: step = mkStep(K_WAIT, 8'h00, WAIT_RESET);
          4'd2: step = mkStep(K_CMD, CMD_SLPOUT, 0);
          4'd3: step = mkStep(K_WAIT, 8'h00, WAIT_SLEEPOUT);
          4'd4: step = mkStep(K_CMD, CMD_COLMOD, 0);
          4'd5: step = mkStep(K_DATA, PARAM_COLMOD, 0);
          4'd6: step = mkStep(K_CMD, CMD_MADCTL, 0);
          4'd7: step = mkStep(K_DATA, PARAM_MADCTL, 0);
          4'd8: step = mkStep(K_CMD, CMD_DISPON, 0);
          default: ;
        endcase
      end
      OP_COLSET, OP_PAGESET: begin
        case (stepIdx)
          4'd0: step = mkStep(K_CMD, (curOp == OP_COLSET) ? CMD_CASET : CMD_PASET, 0);
          4'd1: step = mkStep(K_DATA, curParam[31:24], 0);  // start high byte
          4'd2: step = mkStep(K_DATA, curParam[23:16], 0);
          4'd3: step = mkStep(K_DATA, curParam[15:8], 0);   // end high byte
          4'd4: step = mkStep(K_DATA, curParam[7:0], 0);
          default: ;
        endcase
      end
      OP_FILL: begin
        case (stepIdx)
          4'd0: step = mkStep(K_CMD, CMD_RAMWR, 0);
          4'd1: step = mkStep(K_PIXEL, 8'h00, 0);
          default: ;
        endcase
      end
      OP_DISPON: begin
        case (stepIdx)
          4'd0: step = mkStep(K_CMD, CMD_SLPOUT, 0);
          4'd1: step = mkStep(K_WAIT, 8'h00, WAIT_SLEEPOUT);
          4'd2: step = mkStep(K_CMD, CMD_DISPON, 0);
          4'd3: step = mkStep(K_WAIT, 8'h00, WAIT_DISPON);
          default: ;
        endcase
      end
      OP_DISPOFF: begin
        case (stepIdx)
          4'd0: step = mkStep(K_CMD, CMD_DISPOFF, 0);
          4'd1: step = mkStep(K_WAIT, 8'h00, WAIT_DISPOFF);
          4'd2: step = mkStep(K_CMD, CMD_SLPIN, 0);
          4'd3: step = mkStep(K_WAIT, 8'h00, WAIT_SLEEPIN);
          default: ;
        endcase
      end
      default: ;  // OP_NONE just toggles csx
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state   <= S_IDLE;
      curOp   <= OP_NONE;
      stepIdx <= '0;
      phase   <= 1'b0;
      lowByte <= 1'b0;
      waitCnt <= '0;
      pixLeft <= '0;
      busy    <= 1'b0;
      done    <= 1'b0;
      csx     <= 1'b1;
      dcx     <= 1'b1;
      wrx     <= 1'b1;
      data    <= 8'h00;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            curOp   <= op;
            stepIdx <= '0;
            phase   <= 1'b0;
            lowByte <= 1'b0;
            pixLeft <= count;
            busy    <= 1'b1;
            csx     <= 1'b0;
            state   <= S_RUN;
          end
        end
        S_RUN: begin
          if (!phase) begin
            case (step.kind)
              K_CMD, K_DATA: begin
                wrx   <= 1'b0;
                dcx   <= (step.kind == K_DATA);
                data  <= step.value;
                phase <= 1'b1;
              end
              K_PIXEL: begin
                if (pixLeft == '0) begin
                  stepIdx <= stepIdx + 4'd1;  // empty fill
                end else begin
                  wrx   <= 1'b0;
                  dcx   <= 1'b1;
                  data  <= lowByte ? curParam[7:0] : curParam[15:8];
                  phase <= 1'b1;
                end
              end
              K_WAIT: begin
                waitCnt <= step.len - WAIT_W'(2);  // fetch cycle counts toward the wait
                state   <= S_WAIT;
              end
              default: begin
                csx   <= 1'b1;
                state <= S_CLOSE;
              end
            endcase
          end else begin
            wrx   <= 1'b1;
            phase <= 1'b0;
            if (step.kind == K_PIXEL) begin
              lowByte <= !lowByte;
              if (lowByte) begin
                pixLeft <= pixLeft - 1'b1;
                if (pixLeft == COUNT_W'(1)) begin
                  stepIdx <= stepIdx + 4'd1;
                end
              end
            end else begin
              stepIdx <= stepIdx + 4'd1;
            end
          end
        end
        S_WAIT: begin
          if (waitCnt == '0) begin
            stepIdx <= stepIdx + 4'd1;
            state   <= S_RUN;
          end else begin
            waitCnt <= waitCnt - 1'b1;
          end
        end
        default: begin
          busy  <= 1'b0;
          done  <= 1'b1;
          state <= S_IDLE;
        end
      endcase
    end
  end

  // colour and window words
  always_ff @(posedge clk) begin
    if (state == S_IDLE && start) begin
      curParam <= param;
    end
  end

  aWrxIdle: assert property (@(posedge clk) disable iff (rst) csx |-> wrx)
    else $error("panel %0d: wrx low while csx high", panelIndex);

  aNoStartBusy: assert property (@(posedge clk) disable iff (rst) !(start && busy))
    else $error("panel %0d: start while busy", panelIndex);

endmodule

// ==== axiLiteRegs.sv ====
module axiLiteRegs (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [displayPkg::ADDR_W-1:0]        awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [displayPkg::DATA_W-1:0]        wdata,
  input  logic [displayPkg::DATA_W/8-1:0]      wstrb,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic [1:0]                           bresp,
  output logic                                 bvalid,
  input  logic                                 bready,
  input  logic [displayPkg::ADDR_W-1:0]        araddr,
  input  logic                                 arvalid,
  output logic                                 arready,
  output logic [displayPkg::DATA_W-1:0]        rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready,
  output logic [displayPkg::NUM_PANELS-1:0]    start,
  output displayPkg::panelOp_t                 op [displayPkg::NUM_PANELS],
  output logic [displayPkg::DATA_W-1:0]        param [displayPkg::NUM_PANELS],
  output logic [displayPkg::COUNT_W-1:0]       count [displayPkg::NUM_PANELS],
  input  logic [displayPkg::NUM_PANELS-1:0]    busy,
  input  logic [displayPkg::NUM_PANELS-1:0]    doneBits,
  output logic [displayPkg::NUM_PANELS-1:0]    clearMask,
  output logic                                 clearStrobe,
  output logic [displayPkg::NUM_PANELS-1:0]    irqEn
);
  import displayPkg::*;

  logic wrFire;
  logic rdFire;
  logic [DATA_W-1:0] wMask;
  logic wrHit;
  logic [PANEL_BITS-1:0] wrPanel;
  logic [ADDR_W-1:0] wrSub;
  logic [PANEL_BITS-1:0] rdPanel;
  logic [ADDR_W-1:0] rdSub;
  logic [DATA_W-1:0] rdValue;
  logic rdMapped;

  function automatic logic panelHit(input logic [ADDR_W-1:0] addr);
    return (addr >= PANEL_BASE) && (((addr - PANEL_BASE) / PANEL_STRIDE) < NUM_PANELS);
  endfunction

  function automatic logic [PANEL_BITS-1:0] panelOf(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] slot;
    slot = (addr - PANEL_BASE) / PANEL_STRIDE;
    return slot[PANEL_BITS-1:0];
  endfunction

  function automatic logic [ADDR_W-1:0] subOf(input logic [ADDR_W-1:0] addr);
    return (addr - PANEL_BASE) % PANEL_STRIDE;
  endfunction

  // aw and w taken together, nothing new while a response waits
  assign wrFire  = awvalid && wvalid && !bvalid;
  assign awready = wrFire;
  assign wready  = wrFire;
  assign rdFire  = arvalid && !rvalid;
  assign arready = !rvalid;

  always_comb begin
    for (int i = 0; i < DATA_W / 8; i++) begin
      wMask[8*i +: 8] = {8{wstrb[i]}};
    end
  end

  assign wrHit   = panelHit(awaddr);
  assign wrPanel = panelOf(awaddr);
  assign wrSub   = subOf(awaddr);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      bvalid      <= 1'b0;
      bresp       <= RESP_OKAY;
      start       <= '0;
      irqEn       <= '0;
      clearStrobe <= 1'b0;
      clearMask   <= '0;
      for (int i = 0; i < NUM_PANELS; i++) begin
        op[i] <= OP_NONE;
      end
    end else begin
      start       <= '0;  // one-cycle pulses
      clearStrobe <= 1'b0;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (wrFire) begin
        bvalid <= 1'b1;
        bresp  <= RESP_OKAY;
        if (awaddr == REG_STATUS) begin
          clearStrobe <= 1'b1;
          clearMask   <= wdata[8 +: NUM_PANELS] & wMask[8 +: NUM_PANELS];
        end else if (awaddr == REG_IRQEN) begin
          irqEn <= (irqEn & ~wMask[NUM_PANELS-1:0]) | (wdata[NUM_PANELS-1:0] & wMask[NUM_PANELS-1:0]);
        end else if (wrHit && wrSub == OFS_CMD) begin
          // start still in flight counts as busy
          if (busy[wrPanel] || start[wrPanel]) begin
            bresp <= RESP_SLVERR;
          end else if (wstrb[0]) begin
            start[wrPanel] <= 1'b1;
            op[wrPanel]    <= panelOp_t'(wdata[2:0]);
          end
        end else if (!(wrHit && (wrSub == OFS_PARAM || wrSub == OFS_COUNT))) begin
          bresp <= RESP_SLVERR;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wrFire && wrHit && wrSub == OFS_PARAM) begin
      param[wrPanel] <= (param[wrPanel] & ~wMask) | (wdata & wMask);
    end
    if (wrFire && wrHit && wrSub == OFS_COUNT) begin
      count[wrPanel] <= COUNT_W'((DATA_W'(count[wrPanel]) & ~wMask) | (wdata & wMask));
    end
  end

  assign rdPanel = panelOf(araddr);
  assign rdSub   = subOf(araddr);

  always_comb begin
    rdValue  = '0;
    rdMapped = 1'b1;
    if (araddr == REG_STATUS) begin
      rdValue[NUM_PANELS-1:0]  = busy;
      rdValue[8 +: NUM_PANELS] = doneBits;
    end else if (araddr == REG_IRQEN) begin
      rdValue[NUM_PANELS-1:0] = irqEn;
    end else if (panelHit(araddr) && rdSub == OFS_PARAM) begin
      rdValue = param[rdPanel];
    end else if (panelHit(araddr) && rdSub == OFS_COUNT) begin
      rdValue = DATA_W'(count[rdPanel]);
    end else if (panelHit(araddr) && rdSub == OFS_CMD) begin
      rdValue = DATA_W'(op[rdPanel]);  // last opcode issued
    end else begin
      rdMapped = 1'b0;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rvalid <= 1'b0;
      rresp  <= RESP_OKAY;
    end else begin
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (rdFire) begin
        rvalid <= 1'b1;
        rresp  <= rdMapped ? RESP_OKAY : RESP_SLVERR;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rdFire) begin
      rdata <= rdValue;
    end
  end

  aBrespHeld: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

endmodule

// ==== displayPkg.sv ====
package displayPkg;

  // panel lanes
  localparam int NUM_PANELS = 2;
  localparam int PANEL_BITS = (NUM_PANELS > 1) ? $clog2(NUM_PANELS) : 1;

  // axi widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  localparam int COUNT_W = 20;  // pixels per fill

  typedef enum logic [2:0] {
    OP_NONE,
    OP_INIT,
    OP_COLSET,
    OP_PAGESET,
    OP_FILL,
    OP_DISPON,
    OP_DISPOFF
  } panelOp_t;

  // panel command set
  localparam logic [7:0] CMD_SWRESET  = 8'h01;
  localparam logic [7:0] CMD_SLPIN    = 8'h10;
  localparam logic [7:0] CMD_SLPOUT   = 8'h11;
  localparam logic [7:0] CMD_DISPOFF  = 8'h28;
  localparam logic [7:0] CMD_DISPON   = 8'h29;
  localparam logic [7:0] CMD_CASET    = 8'h2A;
  localparam logic [7:0] CMD_PASET    = 8'h2B;
  localparam logic [7:0] CMD_RAMWR    = 8'h2C;
  localparam logic [7:0] CMD_MADCTL   = 8'h36;
  localparam logic [7:0] CMD_COLMOD   = 8'h3A;
  localparam logic [7:0] PARAM_COLMOD = 8'h55;  // rgb565
  localparam logic [7:0] PARAM_MADCTL = 8'h30;

  // waits in clocks, shortened from the panel datasheet values
  localparam int WAIT_RESET    = 200;
  localparam int WAIT_SLEEPOUT = 480;
  localparam int WAIT_DISPOFF  = 160;
  localparam int WAIT_SLEEPIN  = 160;
  localparam int WAIT_DISPON   = 40;
  localparam int WAIT_W        = $clog2(WAIT_SLEEPOUT + 1);  // longest wait sets the width

  // register map, byte offsets
  localparam logic [ADDR_W-1:0] REG_STATUS   = 8'h00;
  localparam logic [ADDR_W-1:0] REG_IRQEN    = 8'h04;
  localparam logic [ADDR_W-1:0] PANEL_BASE   = 8'h10;
  localparam logic [ADDR_W-1:0] PANEL_STRIDE = 8'h10;
  localparam logic [ADDR_W-1:0] OFS_PARAM    = 8'h0;
  localparam logic [ADDR_W-1:0] OFS_COUNT    = 8'h4;
  localparam logic [ADDR_W-1:0] OFS_CMD      = 8'h8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
